// File: tb/mio_ctrl_tests.txt
# op addr data expected wait: op w write, r read, s status, k clocks
# addr/data/expected hex, wait decimal; addrincr is held at 3
r 00 00000000 00000000 0
r 08 00000000 00000007 0
r 0c 00000000 06020400 0
k 00 00000008 00000002 0
w 00 000552a4 00000000 1
r 00 00000000 000552a4 0
w 00 0002e81a 00000000 1
r 00 00000000 0002e81a 0
w 00 00000000 00000000 1
w 08 00000003 00000000 0
w 0c 03010200 00000000 2
r 08 00000000 00000003 0
r 0c 00000000 03010200 0
k 00 00000004 00000001 0
w 00 00000001 00000000 1
k 00 00000000 00000000 40
w 00 00000000 00000000 1
w 08 00000007 00000000 0
w 0c 06020400 00000000 2
k 00 00000008 00000002 0
s 04 0000003f 00000000 3
s 04 0000003f 00000000 2
s 04 00000015 00000000 4
s 04 00000000 00000000 2
w 04 00000000 00000000 0
s 04 00000000 00000000 1
s 04 0000002a 00000000 3
w 18 00001000 0000101e 10
w 18 fffffff0 00000002 6
r 08 00000000 00000007 5
r 0c 00000000 06020400 3

// File: mio_ctrl_top.f
verilog/mio_pkg.sv
verilog/mio_packet_decode.sv
verilog/mio_regs.sv
verilog/mio_clkgen.sv
verilog/mio_ctrl_top.sv
tb/mio_ctrl_sva.sv
tb/mio_ctrl_tb.sv

// File: Bender.yml
package:
  name: mio_ctrl

sources:
  - files:
      - verilog/mio_pkg.sv
      - verilog/mio_packet_decode.sv
      - verilog/mio_regs.sv
      - verilog/mio_clkgen.sv
      - verilog/mio_ctrl_top.sv
  - target: test
    files:
      - tb/mio_ctrl_sva.sv
      - tb/mio_ctrl_tb.sv

// File: tb/mio_ctrl_tb.sv
module mio_ctrl_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import mio_pkg::*;

   localparam logic [3:0] incr_step   = 4'd3; // amode step, tests file assumes 3
   localparam int         rsp_timeout = 20;   // cycles to wait for access_out
   localparam int         clk_timeout = 600;  // cycles to find link clock edges

   logic        clk;
   logic        nreset;
   logic        access_in;
   emesh_pkt_t  packet_in;
   logic        wait_out;
   logic        access_out;
   emesh_pkt_t  packet_out;
   logic        wait_in;
   logic        tx_full, tx_prog_full, tx_empty;
   logic        rx_full, rx_prog_full, rx_empty;
   logic [3:0]  addrincr;
   logic        tx_en, rx_en, ddr_mode;
   logic        emode, dmode, amode;
   logic [7:0]  datasize;
   logic        lsbfirst;
   logic [4:0]  ctrlmode;
   logic [31:0] dstaddr;
   logic        mio_clk0, mio_clk1;

   integer      seed = 32'hd67d;
   logic [5:0]  flags;        // fifo flags as driven
   logic [7:0]  sticky;       // expected status bits 15:8
   int          checks = 0;
   int          errors = 0;

   assign {tx_full, tx_prog_full, tx_empty, rx_full, rx_prog_full, rx_empty} = flags;

   mio_ctrl_top mio_ctrl_top_inst (.*);

   always #10 clk = ~clk; // 20 ns period

   // ##################################################
   // helpers
   // ##################################################
   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("[FAIL] %0d ns %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #2;
      end
   endtask

   // one-cycle write, never stalled
   task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
      packet_in          = '0;
      packet_in.write    = 1'b1;
      packet_in.datamode = 2'b10;
      packet_in.dstaddr  = addr;
      packet_in.data     = data;
      access_in          = 1'b1;
      @(posedge clk);
      #2;
      access_in = 1'b0;
   endtask

   // read, optional back-pressure for hold cycles, returns response data
   task automatic read_reg(input logic [31:0] addr, input logic [31:0] src,
                           input int hold, output logic [31:0] rdata);
      emesh_pkt_t held;
      int         cycles;
      int         seen;
      packet_in         = '0;
      packet_in.dstaddr = addr;
      packet_in.srcaddr = src;  // comes back as dstaddr
      access_in         = 1'b1;
      wait_in           = (hold > 0);
      @(posedge clk);
      #2;
      access_in = 1'b0;
      cycles    = 0;
      while (!access_out && cycles < rsp_timeout)
      begin
         @(posedge clk);
         #2;
         cycles++;
      end
      if (!access_out)
      begin
         $display("timeout: no read response for srcaddr %0d", src);
         errors++;
         wait_in = 1'b0;
         rdata   = '0;
         return;
      end
      compare_value("packet_out.dstaddr", packet_out.dstaddr, src);
      compare_value("packet_out.write", 32'(packet_out.write), 32'd1);
      compare_value("packet_out.ctrlmode", 32'(packet_out.ctrlmode), 32'd0);
      compare_value("packet_out.datamode", 32'(packet_out.datamode), 32'd2); // word
      held = packet_out;
      repeat (hold) // stalled, everything frozen
      begin
         @(posedge clk);
         #2;
         compare_value("access_out", 32'(access_out), 32'd1);
         compare_value("wait_out", 32'(wait_out), 32'd1);
         compare_value("packet_out.data", packet_out.data, held.data);
         compare_value("packet_out.dstaddr", packet_out.dstaddr, held.dstaddr);
      end
      wait_in = 1'b0;
      seen    = access_out; // taken at the next edge
      repeat (4)
      begin
         @(posedge clk);
         #2;
         seen += access_out;
      end
      compare_value("response count", 32'(seen), 32'd1);
      compare_value("wait_out", 32'(wait_out), 32'd0);
      rdata = held.data;
   endtask

   // config levels against the field layout
   task automatic verify_config(input logic [31:0] cfg);
      compare_value("tx_en", 32'(tx_en), 32'(!cfg[0]));
      compare_value("rx_en", 32'(rx_en), 32'(!cfg[1]));
      compare_value("emode", 32'(emode), 32'(cfg[3:2] == 2'd0));
      compare_value("dmode", 32'(dmode), 32'(cfg[3:2] == 2'd1));
      compare_value("amode", 32'(amode), 32'(cfg[3:2] == 2'd2));
      compare_value("datasize", 32'(datasize), 32'(cfg[11:4]));
      compare_value("ddr_mode", 32'(ddr_mode), 32'(cfg[12]));
      compare_value("lsbfirst", 32'(lsbfirst), 32'(cfg[13]));
      compare_value("ctrlmode", 32'(ctrlmode), 32'(cfg[18:14]));
   endtask

   // random flags held a while, then status read against the model
   task automatic status_step(input logic [5:0] mask, input int hold, input int line_no);
      logic [31:0] rdata;
      flags = 6'($random(seed)) & mask;
      idle(hold);
      sticky = sticky | {2'b00, flags};
      read_reg({26'd0, mio_reg_status, 2'b00}, 32'(line_no), 0, rdata);
      compare_value("status", rdata, {16'd0, sticky, 2'b00, flags});
   endtask

   // period 0 means both clocks must stay low for span cycles
   task automatic measure_clocks(input int period, input int offset, input int span);
      int   cycles;
      int   t0;
      int   t1;
      int   t2;
      logic p0;
      logic p1;
      if (period == 0)
      begin
         repeat (span)
         begin
            @(posedge clk);
            #2;
            compare_value("mio_clk0", 32'(mio_clk0), 32'd0);
            compare_value("mio_clk1", 32'(mio_clk1), 32'd0);
         end
         return;
      end
      t0     = -1;
      t1     = -1;
      t2     = -1;
      cycles = 0;
      p0     = mio_clk0;
      p1     = mio_clk1;
      while (t2 < 0 && cycles < clk_timeout)
      begin
         @(posedge clk);
         #2;
         cycles++;
         if (mio_clk0 && !p0)
         begin
            if (t0 < 0)
               t0 = cycles;
            else
               t2 = cycles; // second rise closes the period
         end
         if (mio_clk1 && !p1 && t0 >= 0 && t1 < 0 && cycles > t0)
            t1 = cycles;
         p0 = mio_clk0;
         p1 = mio_clk1;
      end
      if (t2 < 0)
      begin
         $display("timeout: mio_clk0 did not rise twice within %0d cycles", clk_timeout);
         errors++;
         return;
      end
      compare_value("mio_clk0 period", 32'(t2 - t0), 32'(period));
      compare_value("mio_clk1 offset", 32'(t1 - t0), 32'(offset));
   endtask

   task automatic run_step(input logic [7:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] expv,
                           input int nwait, input int line_no);
      logic [31:0] rdata;
      case (op)
         "w":
         begin
            write_reg(addr, data);
            if (addr[5:2] == mio_reg_status)
            begin
               sticky = data[15:8];
               if (nwait > 0)
                  sticky = sticky | {2'b00, flags}; // flags pile up again
            end
            idle(nwait);
            if (addr[5:2] == mio_reg_config)
               verify_config(data);
            if (addr[5:2] == mio_reg_addr0)
               compare_value("dstaddr", dstaddr, expv); // data + nwait*step
         end
         "r":
         begin
            read_reg(addr, 32'(line_no), nwait, rdata);
            compare_value("packet_out.data", rdata, expv);
         end
         "s":
            status_step(data[5:0], nwait, line_no);
         "k":
            measure_clocks(int'(data), int'(expv), nwait);
         default:
         begin
            $display("unknown op on tests file line %0d", line_no);
            errors++;
         end
      endcase
   endtask

   // ##################################################
   // main sequence
   // ##################################################
   initial
   begin
      int          fd;
      int          c;
      int          n;
      int          line_no;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] expv;
      int          nwait;
      clk       = 1'b0;
      nreset    = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      flags     = 6'd0;
      sticky    = 8'd0;
      addrincr  = incr_step; // constant for the whole run
      repeat (3) @(posedge clk);
      #2;
      nreset = 1'b1;
      verify_config(32'h0); // reset levels

      fd = $fopen("tb/mio_ctrl_tests.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open tb/mio_ctrl_tests.txt");
         errors++;
      end
      else
      begin
         line_no = 1;
         c       = $fgetc(fd);
         while (c != -1)
         begin
            if (c == "#")
            begin
               while (c != "\n" && c != -1)
                  c = $fgetc(fd); // skip comment line
            end
            else if (c != " " && c != "\n" && c != "\r" && c != "\t")
            begin
               n = $fscanf(fd, " %h %h %h %d", addr, data, expv, nwait);
               if (n == 4)
                  run_step(c[7:0], addr, data, expv, nwait, line_no);
               else
               begin
                  $display("malformed tests file line %0d", line_no);
                  errors++;
               end
            end
            if (c == "\n")
               line_no++;
            if (c != -1)
               c = $fgetc(fd);
         end
         $fclose(fd);
      end

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// File: tb/mio_ctrl_sva.sv
module mio_ctrl_sva (
   input logic                clk,
   input logic                nreset,
   input logic                access_out,
   input logic                wait_in,
   input mio_pkg::emesh_pkt_t packet_out,
   input logic                tx_en,
   input logic                mio_clk0,
   input logic                mio_clk1
);
   timeunit 1ns;
   timeprecision 1ps;

   // stalled response frozen on the bus
   stall_hold: assert property (@(posedge clk) disable iff (!nreset)
                                access_out && wait_in |=> $stable(packet_out))
      else $error("packet_out moved while access_out and wait_in were high");

   // reset clears response valid and link clocks
   reset_quiet: assert property (@(posedge clk)
                                 !nreset |=> !access_out && !mio_clk0 && !mio_clk1)
      else $error("access_out or a link clock high during reset");

   // tx off, clocks parked low
   tx_off_quiet: assert property (@(posedge clk) disable iff (!nreset)
                                  !tx_en |=> !mio_clk0 && !mio_clk1)
      else $error("link clock high while tx_en was low");

endmodule

bind mio_ctrl_top mio_ctrl_sva sva_inst (
   .clk        (clk),
   .nreset     (nreset),
   .access_out (access_out),
   .wait_in    (wait_in),
   .packet_out (packet_out),
   .tx_en      (tx_en),
   .mio_clk0   (mio_clk0),
   .mio_clk1   (mio_clk1)
);

// File: verilog/mio_ctrl_top.sv
module mio_ctrl_top (
   input  logic                clk,
   input  logic                nreset,
   // mesh packet ports
   input  logic                access_in,
   input  mio_pkg::emesh_pkt_t packet_in,
   output logic                wait_out,
   output logic                access_out,
   output mio_pkg::emesh_pkt_t packet_out,
   input  logic                wait_in,
   // fifo flags and amode step
   input  logic                tx_full,
   input  logic                tx_prog_full,
   input  logic                tx_empty,
   input  logic                rx_full,
   input  logic                rx_prog_full,
   input  logic                rx_empty,
   input  logic [3:0]          addrincr,
   // config levels
   output logic                tx_en,
   output logic                rx_en,
   output logic                ddr_mode,
   output logic                emode,
   output logic                dmode,
   output logic                amode,
   output logic [7:0]          datasize,
   output logic                lsbfirst,
   output logic [4:0]          ctrlmode,
   output logic [31:0]         dstaddr,
   // link clocks
   output logic                mio_clk0,
   output logic                mio_clk1
);
   import mio_pkg::*;

   logic          write_in;
   logic [31:0]   dstaddr_in;
   logic [31:0]   srcaddr_in;
   logic [31:0]   data_in;
   logic [31:0]   rsp_dstaddr;
   logic [31:0]   rsp_data;
   logic [7:0]    clkdiv;
   logic          clkdiv_write;
   mio_clkphase_t clkphase;

   // ##################################################
   // packet fields in and out
   // ##################################################
   mio_packet_decode decode_inst (
      .packet_in   (packet_in),
      .write_in    (write_in),
      .ctrlmode_in (),             // request ctrlmode not used by regs
      .dstaddr_in  (dstaddr_in),
      .srcaddr_in  (srcaddr_in),
      .data_in     (data_in),
      .rsp_dstaddr (rsp_dstaddr),
      .rsp_data    (rsp_data),
      .packet_out  (packet_out)
   );

   // register file
   mio_regs regs_inst (
      .clk          (clk),
      .nreset       (nreset),
      .access_in    (access_in),
      .write_in     (write_in),
      .dstaddr_in   (dstaddr_in),
      .srcaddr_in   (srcaddr_in),
      .data_in      (data_in),
      .wait_in      (wait_in),
      .wait_out     (wait_out),
      .access_out   (access_out),
      .rsp_dstaddr  (rsp_dstaddr),
      .rsp_data     (rsp_data),
      .addrincr     (addrincr),
      .tx_full      (tx_full),
      .tx_prog_full (tx_prog_full),
      .tx_empty     (tx_empty),
      .rx_full      (rx_full),
      .rx_prog_full (rx_prog_full),
      .rx_empty     (rx_empty),
      .tx_en        (tx_en),
      .rx_en        (rx_en),
      .ddr_mode     (ddr_mode),
      .emode        (emode),
      .dmode        (dmode),
      .amode        (amode),
      .lsbfirst     (lsbfirst),
      .datasize     (datasize),
      .ctrlmode     (ctrlmode),
      .dstaddr      (dstaddr),
      .clkdiv       (clkdiv),
      .clkdiv_write (clkdiv_write),
      .clkphase     (clkphase)
   );

   // link clock generator
   mio_clkgen clkgen_inst (
      .clk          (clk),
      .nreset       (nreset),
      .tx_en        (tx_en),
      .clkdiv       (clkdiv),
      .clkdiv_write (clkdiv_write),
      .clkphase     (clkphase),
      .mio_clk0     (mio_clk0),
      .mio_clk1     (mio_clk1)
   );

endmodule

// File: verilog/mio_clkgen.sv
module mio_clkgen (
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   tx_en,        // clocks forced low when off
   input  logic [7:0]             clkdiv,       // period is clkdiv+1
   input  logic                   clkdiv_write,
   input  mio_pkg::mio_clkphase_t clkphase,
   output logic                   mio_clk0,
   output logic                   mio_clk1
);

   logic [7:0] cnt; // phase counter, 0..clkdiv

   // next value of one link clock from its edge positions
   function automatic logic next_edge(input logic       cur,
                                      input logic [7:0] count,
                                      input logic [7:0] rise,
                                      input logic [7:0] fall);
      logic nxt;
      nxt = cur;
      if (count == fall)
         nxt = 1'b0;
      if (count == rise)
         nxt = 1'b1; // rise wins on a tie
      return nxt;
   endfunction

   // ##################################################
   // divider counter
   // ##################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         cnt <= 8'd0;
      else if (clkdiv_write)
         cnt <= 8'd0;              // new period starts clean
      else if (cnt >= clkdiv)
         cnt <= 8'd0;              // wrap, also covers a smaller divider
      else
         cnt <= cnt + 8'd1;

   // ##################################################
   // link clocks
   // ##################################################
   // straight from flops so no decode glitches reach the pins
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         mio_clk0 <= 1'b0;
         mio_clk1 <= 1'b0;
      end
      else if (!tx_en)
      begin
         mio_clk0 <= 1'b0;
         mio_clk1 <= 1'b0;
      end
      else
      begin
         mio_clk0 <= next_edge(mio_clk0, cnt, clkphase.rise0, clkphase.fall0);
         mio_clk1 <= next_edge(mio_clk1, cnt, clkphase.rise1, clkphase.fall1);
      end

endmodule

// File: verilog/mio_regs.sv
module mio_regs (
   input  logic                  clk,
   input  logic                  nreset,
   // decoded request
   input  logic                  access_in,
   input  logic                  write_in,
   input  logic [31:0]           dstaddr_in,
   input  logic [31:0]           srcaddr_in,
   input  logic [31:0]           data_in,
   input  logic                  wait_in,     // response held off
   output logic                  wait_out,
   // read response
   output logic                  access_out,
   output logic [31:0]           rsp_dstaddr,
   output logic [31:0]           rsp_data,
   // status / amode inputs
   input  logic [3:0]            addrincr,
   input  logic                  tx_full,
   input  logic                  tx_prog_full,
   input  logic                  tx_empty,
   input  logic                  rx_full,
   input  logic                  rx_prog_full,
   input  logic                  rx_empty,
   // config levels
   output logic                  tx_en,
   output logic                  rx_en,
   output logic                  ddr_mode,
   output logic                  emode,
   output logic                  dmode,
   output logic                  amode,
   output logic                  lsbfirst,
   output logic [7:0]            datasize,
   output logic [4:0]            ctrlmode,
   output logic [31:0]           dstaddr,
   // clock setup
   output logic [7:0]            clkdiv,
   output logic                  clkdiv_write, // restarts the divider
   output mio_pkg::mio_clkphase_t clkphase
);
   import mio_pkg::*;

   logic [3:0]  reg_idx;
   logic        reg_write;
   logic        rd_req;
   logic        stall;
   logic        config_write;
   logic        status_write;
   logic        clkphase_write;
   logic        addr0_write;
   logic        addr1_write;
   mio_cfg_u    cfg_reg;
   logic [7:0]  status_in;
   logic [15:0] status_reg;  // 15:8 sticky, 7:0 immediate
   logic [63:0] addr_reg;
   logic [31:0] rd_data;

   // ##################################################
   // decode
   // ##################################################
   assign reg_idx   = dstaddr_in[5:2];
   assign stall     = access_out & wait_in;         // response stuck on output
   assign wait_out  = stall;
   assign reg_write = access_in & write_in;         // writes never stall
   assign rd_req    = access_in & ~write_in & ~stall;

   assign config_write   = reg_write & (reg_idx == mio_reg_config);
   assign status_write   = reg_write & (reg_idx == mio_reg_status);
   assign clkdiv_write   = reg_write & (reg_idx == mio_reg_clkdiv);
   assign clkphase_write = reg_write & (reg_idx == mio_reg_clkphase);
   assign addr0_write    = reg_write & (reg_idx == mio_reg_addr0);
   assign addr1_write    = reg_write & (reg_idx == mio_reg_addr1);

   // config
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         cfg_reg.raw <= def_cfg;
      else if (config_write)
         cfg_reg.raw <= data_in;

   assign tx_en    = ~cfg_reg.fld.tx_disable;
   assign rx_en    = ~cfg_reg.fld.rx_disable;
   assign emode    = cfg_reg.fld.mode == mio_mode_emesh;
   assign dmode    = cfg_reg.fld.mode == mio_mode_data;  // streaming
   assign amode    = cfg_reg.fld.mode == mio_mode_auto;
   assign datasize = cfg_reg.fld.datasize;
   assign ddr_mode = cfg_reg.fld.ddr;
   assign lsbfirst = cfg_reg.fld.lsbfirst;
   assign ctrlmode = cfg_reg.fld.ctrlmode;

   // ##################################################
   // status
   // ##################################################
   assign status_in = {2'b00, tx_full, tx_prog_full, tx_empty,
                       rx_full, rx_prog_full, rx_empty};

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         status_reg <= '0;
      else if (status_write)
      begin
         status_reg[15:8] <= data_in[15:8]; // zeros clear sticky flags
         status_reg[7:0]  <= status_in;
      end
      else
      begin
         status_reg[15:8] <= status_reg[15:8] | status_in; // accumulate
         status_reg[7:0]  <= status_in;
      end

   // clock divider and phases
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         clkdiv <= def_clkdiv;
      else if (clkdiv_write)
         clkdiv <= data_in[7:0];

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         clkphase.rise0 <= def_rise0;
         clkphase.fall0 <= def_fall0;
         clkphase.rise1 <= def_rise1;
         clkphase.fall1 <= def_fall1;
      end
      else if (clkphase_write)
         clkphase <= mio_clkphase_t'(data_in);

   // ##################################################
   // auto address (amode)
   // ##################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         addr_reg <= '0;
      else if (addr0_write)
         addr_reg[31:0] <= data_in;
      else if (addr1_write)
         addr_reg[63:32] <= data_in;
      else
         addr_reg <= addr_reg + 64'(addrincr); // steps every idle cycle

   assign dstaddr = addr_reg[31:0];

   // ##################################################
   // read path
   // ##################################################
   always_comb
   begin
      case (reg_idx)
         mio_reg_config   : rd_data = cfg_reg.raw;
         mio_reg_status   : rd_data = {16'd0, status_reg};
         mio_reg_clkdiv   : rd_data = {24'd0, clkdiv};
         mio_reg_clkphase : rd_data = clkphase;
         mio_reg_idelay   : rd_data = 32'd0;     // no delay lines here
         mio_reg_odelay   : rd_data = 32'd0;
         mio_reg_addr0    : rd_data = addr_reg[31:0];
         mio_reg_addr1    : rd_data = addr_reg[63:32];
         default          : rd_data = 32'd0;     // unmapped
      endcase
   end

   // response valid, held while stalled
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         access_out <= 1'b0;
      else if (!stall)
         access_out <= rd_req;

   always_ff @(posedge clk)
      if (rd_req)
      begin
         rsp_dstaddr <= srcaddr_in; // back to requester
         rsp_data    <= rd_data;
      end

endmodule

// File: verilog/mio_packet_decode.sv
module mio_packet_decode (
   // request side
   input  mio_pkg::emesh_pkt_t packet_in,
   output logic                write_in,
   output logic [4:0]          ctrlmode_in,
   output logic [31:0]         dstaddr_in,
   output logic [31:0]         srcaddr_in,
   output logic [31:0]         data_in,
   // response side
   input  logic [31:0]         rsp_dstaddr,
   input  logic [31:0]         rsp_data,
   output mio_pkg::emesh_pkt_t packet_out
);
   import mio_pkg::*;

   logic [pw-1:0] rsp_flat; // response before cast back to struct

   // ##################################################
   // unpack request
   // ##################################################
   assign write_in    = packet_in.write;
   assign ctrlmode_in = packet_in.ctrlmode;
   assign dstaddr_in  = packet_in.dstaddr;   // register select lives here
   assign srcaddr_in  = packet_in.srcaddr;   // where a read goes back to
   assign data_in     = packet_in.data;

   // ##################################################
   // pack response
   // ##################################################
   // read responses return as word writes to the requester
   assign rsp_flat = {32'd0,              // srcaddr, unused on return
                      rsp_data,
                      rsp_dstaddr,
                      5'd0,               // ctrlmode
                      mio_datamode_word,
                      1'b1};              // write

   assign packet_out = emesh_pkt_t'(rsp_flat);

endmodule

// File: verilog/mio_pkg.sv
package mio_pkg;

   // ##################################################
   // widths
   // ##################################################
   localparam int aw = 32;            // address / data width
   localparam int pw = 2*aw + 40;     // flat mesh packet, 104 bits

   // register index, taken from dstaddr[5:2]
   localparam logic [3:0] mio_reg_config   = 4'd0;
   localparam logic [3:0] mio_reg_status   = 4'd1;
   localparam logic [3:0] mio_reg_clkdiv   = 4'd2;
   localparam logic [3:0] mio_reg_clkphase = 4'd3;
   localparam logic [3:0] mio_reg_idelay   = 4'd4; // not implemented, reads 0
   localparam logic [3:0] mio_reg_odelay   = 4'd5; // not implemented, reads 0
   localparam logic [3:0] mio_reg_addr0    = 4'd6; // auto address, low word
   localparam logic [3:0] mio_reg_addr1    = 4'd7; // auto address, high word

   // ##################################################
   // reset defaults
   // ##################################################
   localparam logic [31:0] def_cfg    = 32'd0; // tx+rx on, emode
   localparam logic [7:0]  def_clkdiv = 8'd7;  // divide by 8

   // phases derived from the divider period
   localparam logic [7:0] def_rise0 = 8'd0;                             // 0 deg
   localparam logic [7:0] def_fall0 = (def_clkdiv + 8'd1) >> 1;         // 180 deg
   localparam logic [7:0] def_rise1 = (def_clkdiv + 8'd1) >> 2;         // 90 deg
   localparam logic [7:0] def_fall1 = def_rise1 + def_fall0;            // 270 deg

   // config mode field
   localparam logic [1:0] mio_mode_emesh = 2'd0;
   localparam logic [1:0] mio_mode_data  = 2'd1;
   localparam logic [1:0] mio_mode_auto  = 2'd2;

   localparam logic [1:0] mio_datamode_word = 2'b10; // 32 bit transfer

   // ##################################################
   // types
   // ##################################################
   typedef struct packed {
      logic [aw-1:0] srcaddr;  // read return address
      logic [aw-1:0] data;
      logic [aw-1:0] dstaddr;
      logic [4:0]    ctrlmode;
      logic [1:0]    datamode;
      logic          write;    // bit 0
   } emesh_pkt_t;

   typedef struct packed {
      logic [12:0] unused;
      logic [4:0]  ctrlmode;   // ctrlmode for amode packets
      logic        lsbfirst;
      logic        ddr;
      logic [7:0]  datasize;   // flits per packet
      logic [1:0]  mode;       // emesh / data / auto
      logic        rx_disable;
      logic        tx_disable; // bit 0
   } mio_cfg_t;

   // config word stored raw, read back as fields
   typedef union packed {
      logic [31:0] raw;
      mio_cfg_t    fld;
   } mio_cfg_u;

   typedef struct packed {
      logic [7:0] fall1;
      logic [7:0] rise1;
      logic [7:0] fall0;
      logic [7:0] rise0;      // bits 7:0
   } mio_clkphase_t;

endpackage
